/* hdl/iob_bus_pkg.sv */
package iob_bus_pkg;

   // native memory bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 12;  // byte address
   localparam int STRB_W = DATA_W / 8;

   // master to slave
   // nonzero wstrb marks a write, zero wstrb a read
   typedef struct packed {
      logic              avalid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } iob_req_t;

   // slave to master
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;  // one-cycle pulse after an accepted read
      logic              ready;   // level, request taken when avalid is also high
   } iob_resp_t;

endpackage

/* hdl/iob_map_pkg.sv */
package iob_map_pkg;
   import iob_bus_pkg::*;

   localparam int N_MASTERS_C = 2;
   localparam int N_SLAVES_C  = 2;

   // slave number equals the value of the region bit
   localparam int SLV_RAM = 0;
   localparam int SLV_REG = 1;

   localparam int RAM_AW = 9;  // 512 words

   // register block layout
   localparam int REG_IDX_W     = 2;
   localparam int REG_SCRATCH_N = 3;  // indices 0 to 2
   localparam int REG_CNT_IDX   = 3;  // read-only write count

   localparam int BYTE_OFF_W = $clog2(STRB_W);
   localparam int REG_PAD_W  = ADDR_W - 1 - REG_IDX_W - BYTE_OFF_W;

   typedef struct packed {
      logic                  region;
      logic [RAM_AW-1:0]     word;
      logic [BYTE_OFF_W-1:0] boff;
   } ram_view_t;

   typedef struct packed {
      logic                  region;
      logic [REG_PAD_W-1:0]  pad;   // not decoded
      logic [REG_IDX_W-1:0]  idx;
      logic [BYTE_OFF_W-1:0] boff;
   } reg_view_t;

   // same address word, decoded by the RAM and by the register block
   typedef union packed {
      ram_view_t ram;
      reg_view_t regs;
   } iob_addr_u;

endpackage

/* hdl/iob_merge.sv */
module iob_merge
   import iob_bus_pkg::*;
#(
   parameter int N_MASTERS = 2
) (
   input  logic                      clk_i,
   input  logic                      arst_n_i,

   // masters
   input  iob_req_t  [N_MASTERS-1:0] m_req_i,
   output iob_resp_t [N_MASTERS-1:0] m_resp_o,

   // shared bus
   output iob_req_t                  s_req_o,
   input  iob_resp_t                 s_resp_i
);

   localparam int SEL_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;

   logic [SEL_W-1:0] sel;
   logic [SEL_W-1:0] sel_q;  // master that owned the bus last cycle

   // priority encoder, highest index wins
   always_comb begin
      sel = sel_q;  // hold while the bus is not ready
      if (s_resp_i.ready) begin
         sel = '0;
         for (int k = 0; k < N_MASTERS; k++) begin
            if (m_req_i[k].avalid) begin
               sel = SEL_W'(k);
            end
         end
      end
   end

   assign s_req_o = m_req_i[sel];

   // ready follows the current winner,
   // read data follows last cycle's winner
   always_comb begin
      for (int j = 0; j < N_MASTERS; j++) begin
         m_resp_o[j] = '0;
         if (SEL_W'(j) == sel_q) begin
            m_resp_o[j].rdata  = s_resp_i.rdata;
            m_resp_o[j].rvalid = s_resp_i.rvalid;
         end
         if (SEL_W'(j) == sel) begin
            m_resp_o[j].ready = s_resp_i.ready;  // losers see ready low
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sel_q <= '0;
      end else begin
         sel_q <= sel;  // every cycle
      end
   end

endmodule

/* hdl/iob_split.sv */
module iob_split
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
#(
   parameter int N_SLAVES = 2
) (
   input  logic                     clk_i,
   input  logic                     arst_n_i,

   // shared bus
   input  iob_req_t                 m_req_i,
   output iob_resp_t                m_resp_o,

   // slaves
   output iob_req_t  [N_SLAVES-1:0] s_req_o,
   input  iob_resp_t [N_SLAVES-1:0] s_resp_i
);

   localparam int SEL_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   iob_addr_u        addr_u;
   logic [SEL_W-1:0] sel;
   logic [SEL_W-1:0] sel_q;  // slave addressed last cycle

   assign addr_u = m_req_i.addr;
   assign sel    = SEL_W'(addr_u.ram.region);  // region bit picks the slave

   // same request to all slaves, avalid only where it belongs
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_req_o[i]        = m_req_i;
         s_req_o[i].avalid = m_req_i.avalid && (sel == SEL_W'(i));
      end
   end

   always_comb begin
      m_resp_o        = '0;
      m_resp_o.rdata  = s_resp_i[sel_q].rdata;
      m_resp_o.rvalid = s_resp_i[sel_q].rvalid;
      m_resp_o.ready  = s_resp_i[sel].ready;  // same cycle as the request
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sel_q <= '0;
      end else begin
         sel_q <= sel;
      end
   end

endmodule

/* hdl/iob_ram_slave.sv */
module iob_ram_slave
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  iob_req_t  req_i,
   output iob_resp_t resp_o
);

   logic [DATA_W-1:0] mem [2**RAM_AW];

   iob_addr_u         addr_u;
   logic              wr_acc;
   logic              rd_acc;
   logic [DATA_W-1:0] rdata_q;
   logic              rvalid_q;

   assign addr_u = req_i.addr;

   // ready is always high, so avalid alone means accepted
   assign wr_acc = req_i.avalid && (|req_i.wstrb);
   assign rd_acc = req_i.avalid && (req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (wr_acc) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (req_i.wstrb[b]) begin
               mem[addr_u.ram.word][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
            end
         end
      end
      if (rd_acc) begin
         rdata_q <= mem[addr_u.ram.word];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_acc;  // single pulse per read
      end
   end

   assign resp_o.rdata  = rdata_q;
   assign resp_o.rvalid = rvalid_q;
   assign resp_o.ready  = 1'b1;

endmodule

/* hdl/iob_regs_slave.sv */
module iob_regs_slave
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  iob_req_t  req_i,
   output iob_resp_t resp_o
);

   iob_addr_u         addr_u;
   logic              wr_acc;
   logic              rd_acc;
   logic              is_cnt;
   logic [DATA_W-1:0] scratch [REG_SCRATCH_N];
   logic [DATA_W-1:0] wr_cnt;  // count of accepted writes
   logic [DATA_W-1:0] rd_word;
   logic [DATA_W-1:0] rdata_q;
   logic              rvalid_q;

   assign addr_u = req_i.addr;
   assign is_cnt = (int'(addr_u.regs.idx) == REG_CNT_IDX);

   // always ready
   assign wr_acc = req_i.avalid && (|req_i.wstrb);
   assign rd_acc = req_i.avalid && (req_i.wstrb == '0);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < REG_SCRATCH_N; i++) begin
            scratch[i] <= '0;
         end
         wr_cnt   <= '0;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_acc;
         if (wr_acc) begin
            wr_cnt <= wr_cnt + DATA_W'(1);  // counts writes to the count register too
            if (!is_cnt) begin
               for (int b = 0; b < STRB_W; b++) begin
                  if (req_i.wstrb[b]) begin
                     scratch[addr_u.regs.idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                  end
               end
            end
         end
      end
   end

   // read mux
   always_comb begin
      rd_word = wr_cnt;
      if (!is_cnt) begin
         rd_word = scratch[addr_u.regs.idx];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_acc) begin
         rdata_q <= rd_word;
      end
   end

   assign resp_o.rdata  = rdata_q;
   assign resp_o.rvalid = rvalid_q;
   assign resp_o.ready  = 1'b1;

endmodule

/* hdl/iob_subsys_top.sv */
module iob_subsys_top
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  iob_req_t  [N_MASTERS_C-1:0] m_req_i,
   output iob_resp_t [N_MASTERS_C-1:0] m_resp_o
);

   // merged bus
   iob_req_t                   bus_req;
   iob_resp_t                  bus_resp;

   // per-slave buses, indexed by region
   iob_req_t  [N_SLAVES_C-1:0] slv_req;
   iob_resp_t [N_SLAVES_C-1:0] slv_resp;

   iob_merge #(
      .N_MASTERS(N_MASTERS_C)
   ) i_merge (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .m_req_i (m_req_i),
      .m_resp_o(m_resp_o),
      .s_req_o (bus_req),
      .s_resp_i(bus_resp)
   );

   iob_split #(
      .N_SLAVES(N_SLAVES_C)
   ) i_split (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .m_req_i (bus_req),
      .m_resp_o(bus_resp),
      .s_req_o (slv_req),
      .s_resp_i(slv_resp)
   );

   iob_ram_slave i_ram (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (slv_req[SLV_RAM]),
      .resp_o  (slv_resp[SLV_RAM])
   );

   iob_regs_slave i_regs (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (slv_req[SLV_REG]),
      .resp_o  (slv_resp[SLV_REG])
   );

endmodule

/* sim/iob_merge_chk.sv */
module iob_merge_chk
   import iob_bus_pkg::*;
#(
   parameter int N_MASTERS = 2
) (
   input logic                      clk_i,
   input logic                      arst_n_i,
   input iob_req_t  [N_MASTERS-1:0] m_req_i,
   input iob_resp_t [N_MASTERS-1:0] m_resp_i
);

   logic [N_MASTERS-1:0] rdy_vec;
   logic [N_MASTERS-1:0] rvalid_vec;
   logic [N_MASTERS-1:0] rd_acc_vec;  // read taken this cycle, per master

   always_comb begin
      for (int k = 0; k < N_MASTERS; k++) begin
         rdy_vec[k]    = m_resp_i[k].ready;
         rvalid_vec[k] = m_resp_i[k].rvalid;
         rd_acc_vec[k] = m_req_i[k].avalid && m_resp_i[k].ready && (m_req_i[k].wstrb == '0);
      end
   end

   a_one_ready : assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(rdy_vec))
      else $error("ready given to several masters: %b", rdy_vec);

   a_one_rvalid : assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(rvalid_vec))
      else $error("rvalid sent to several masters: %b", rvalid_vec);

   // response goes back to the master whose read was taken
   a_rd_routed : assert property (@(posedge clk_i) disable iff (!arst_n_i)
         (rd_acc_vec != '0) |=> (rvalid_vec == $past(rd_acc_vec)))
      else $error("read response misrouted: rvalid %b", rvalid_vec);

endmodule

bind iob_merge iob_merge_chk #(
   .N_MASTERS(N_MASTERS)
) i_merge_chk (
   .clk_i   (clk_i),
   .arst_n_i(arst_n_i),
   .m_req_i (m_req_i),
   .m_resp_i(m_resp_o)
);

/* sim/tb_iob_subsys.sv */
module tb_iob_subsys
   import iob_bus_pkg::*;
   import iob_map_pkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int MAX_WAIT   = 16;  // cycles a master may wait for ready
   localparam int RAND_WORDS = 16;
   localparam int RAND_CYC   = 400;
   // cycle budget of reset and of each test
   localparam int TEST_CYC   = 3 + 20 + 30 + 30 + 10 + (RAND_WORDS * 2 + RAND_CYC + 10);
   localparam int WATCHDOG_T = TEST_CYC * CLK_PERIOD + 200;

   logic                        clk_i;
   logic                        arst_n_i;
   iob_req_t  [N_MASTERS_C-1:0] m_req;
   iob_resp_t [N_MASTERS_C-1:0] m_resp;

   // reference model, reg_mdl[REG_CNT_IDX] is the write count
   logic [DATA_W-1:0] ram_mdl [2**RAM_AW];
   logic [DATA_W-1:0] reg_mdl [4];
   int n_checks;
   int n_errors;
   int n_tests;

   iob_subsys_top i_dut (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .m_req_i (m_req),
      .m_resp_o(m_resp)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   function automatic logic [ADDR_W-1:0] ram_addr(input int word);
      return ADDR_W'(word * 4);
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input int idx);
      return ADDR_W'((1 << (ADDR_W - 1)) + idx * 4);  // region bit set
   endfunction

   function automatic logic [DATA_W-1:0] fill_word(input int w);
      return {~16'(w), 16'(w) ^ 16'hC3A5};
   endfunction

   function automatic logic [DATA_W-1:0] merge_strb(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] wdata,
                                                    input logic [STRB_W-1:0] wstrb);
      logic [DATA_W-1:0] res;
      res = old;
      for (int b = 0; b < STRB_W; b++) begin
         if (wstrb[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
      end
      return res;
   endfunction

   function automatic logic [DATA_W-1:0] mdl_read(input logic [ADDR_W-1:0] addr);
      if (addr[ADDR_W-1]) begin
         return reg_mdl[addr[3:2]];
      end else begin
         return ram_mdl[addr[ADDR_W-2:2]];
      end
   endfunction

   task automatic mdl_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic [STRB_W-1:0] wstrb);
      if (addr[ADDR_W-1]) begin
         if (addr[3:2] != 2'(REG_CNT_IDX)) begin
            reg_mdl[addr[3:2]] = merge_strb(reg_mdl[addr[3:2]], wdata, wstrb);
         end
         reg_mdl[REG_CNT_IDX] = reg_mdl[REG_CNT_IDX] + 32'd1;  // any register write
      end else begin
         ram_mdl[addr[ADDR_W-2:2]] = merge_strb(ram_mdl[addr[ADDR_W-2:2]], wdata, wstrb);
      end
   endtask

   function automatic iob_req_t rand_req();
      iob_req_t r;
      int kind;
      r = '0;
      kind = int'($urandom_range(0, 9));
      if (kind >= 2) begin  // otherwise idle
         r.avalid = 1'b1;
         if (kind < 6) begin
            r.addr = ram_addr(int'($urandom_range(0, RAND_WORDS - 1)));
         end else begin
            r.addr = reg_addr(int'($urandom_range(0, REG_SCRATCH_N - 1)));
         end
         r.addr[1:0] = 2'($urandom_range(0, 3));  // byte offset, not decoded
         if ($urandom_range(0, 1) == 1) begin
            r.wdata = $urandom;
            r.wstrb = STRB_W'($urandom_range(1, (1 << STRB_W) - 1));
         end
      end
      return r;
   endfunction

   task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("** Error: %s expected 0x%08h, got 0x%08h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic test_done(input string name, input int errs0);
      n_tests++;
      if (n_errors == errs0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, n_errors - errs0);
      end
   endtask

   // one transfer by one master, read data checked against the model
   task automatic bus_access(input int m, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb);
      iob_req_t          req;
      logic [DATA_W-1:0] exp;
      int                waited;
      req = '0;
      req.avalid = 1'b1;
      req.addr = addr;
      req.wdata = wdata;
      req.wstrb = wstrb;
      exp = '0;
      waited = 0;
      @(posedge clk_i);
      m_req[m] <= req;
      @(negedge clk_i);
      while (!m_resp[m].ready && waited < MAX_WAIT) begin
         waited++;
         @(negedge clk_i);
      end
      if (!m_resp[m].ready) begin
         n_errors++;
         $display("master %0d saw no ready within %0d cycles", m, MAX_WAIT);
      end
      check_val($sformatf("m_resp_o[%0d].rvalid", m), '0, DATA_W'(m_resp[m].rvalid));
      if (wstrb == '0) exp = mdl_read(addr);
      else mdl_write(addr, wdata, wstrb);
      @(posedge clk_i);
      m_req[m].avalid <= 1'b0;  // accepted at this edge
      @(negedge clk_i);
      check_val($sformatf("m_resp_o[%0d].rvalid", m), DATA_W'(wstrb == '0),
                DATA_W'(m_resp[m].rvalid));
      if (wstrb == '0) check_val($sformatf("m_resp_o[%0d].rdata", m), exp, m_resp[m].rdata);
   endtask

   task automatic test_ram_rw();
      int errs0;
      errs0 = n_errors;
      bus_access(0, ram_addr('h5A), 32'h1234_5678, 4'hF);
      bus_access(0, ram_addr('h5A), '0, '0);
      bus_access(0, ram_addr('h5A), 32'hAABB_CCDD, 4'b0101);
      bus_access(0, ram_addr('h5A) + 12'd2, '0, '0);
      bus_access(0, ram_addr('h1FF) + 12'd3, $urandom, 4'hF);  // top word
      bus_access(0, ram_addr('h1FF), '0, '0);
      test_done("ram write/read", errs0);
   endtask

   task automatic test_regs();
      int errs0;
      errs0 = n_errors;
      for (int i = 0; i < REG_SCRATCH_N; i++) begin
         bus_access(1, reg_addr(i), $urandom, 4'hF);
         bus_access(1, reg_addr(i), $urandom, STRB_W'(32'h6 << i));
         bus_access(1, reg_addr(i), '0, '0);
      end
      test_done("scratch registers", errs0);
   endtask

   task automatic test_wr_count();
      int errs0;
      errs0 = n_errors;
      bus_access(1, reg_addr(REG_CNT_IDX), '0, '0);
      bus_access(1, reg_addr(REG_CNT_IDX), 32'hFFFF_FFFF, 4'hF);  // ignored but counted
      bus_access(1, reg_addr(REG_CNT_IDX), '0, '0);
      bus_access(0, reg_addr(REG_CNT_IDX), 32'h0, 4'h3);
      bus_access(0, ram_addr(3), 32'h5555_AAAA, 4'hF);  // RAM writes do not count
      bus_access(1, reg_addr(2), 32'h0BAD_F00D, 4'b1000);
      bus_access(0, reg_addr(REG_CNT_IDX), '0, '0);
      test_done("write count", errs0);
   endtask

   task automatic test_contention();
      int                errs0;
      iob_req_t          r0;
      iob_req_t          r1;
      logic [DATA_W-1:0] exp0;
      logic [DATA_W-1:0] exp1;
      errs0 = n_errors;
      r0 = '0;
      r0.avalid = 1'b1;
      r0.addr = ram_addr('h5A);
      r1 = '0;
      r1.avalid = 1'b1;
      r1.addr = reg_addr(0);
      @(posedge clk_i);
      m_req[0] <= r0;
      m_req[1] <= r1;
      @(negedge clk_i);
      check_val("m_resp_o[1].ready", 32'd1, DATA_W'(m_resp[1].ready));
      check_val("m_resp_o[0].ready", 32'd0, DATA_W'(m_resp[0].ready));
      exp1 = mdl_read(r1.addr);
      @(posedge clk_i);
      m_req[1].avalid <= 1'b0;  // master 0 keeps holding
      @(negedge clk_i);
      check_val("m_resp_o[0].ready", 32'd1, DATA_W'(m_resp[0].ready));
      check_val("m_resp_o[1].rvalid", 32'd1, DATA_W'(m_resp[1].rvalid));
      check_val("m_resp_o[1].rdata", exp1, m_resp[1].rdata);
      check_val("m_resp_o[0].rvalid", 32'd0, DATA_W'(m_resp[0].rvalid));
      exp0 = mdl_read(r0.addr);
      @(posedge clk_i);
      m_req[0].avalid <= 1'b0;
      @(negedge clk_i);
      check_val("m_resp_o[0].rvalid", 32'd1, DATA_W'(m_resp[0].rvalid));
      check_val("m_resp_o[0].rdata", exp0, m_resp[0].rdata);
      check_val("m_resp_o[1].rvalid", 32'd0, DATA_W'(m_resp[1].rvalid));
      test_done("contention", errs0);
   endtask

   task automatic check_rd_resp(input logic [N_MASTERS_C-1:0] pend,
                                input logic [N_MASTERS_C-1:0][DATA_W-1:0] exp_rd);
      for (int m = 0; m < N_MASTERS_C; m++) begin
         check_val($sformatf("m_resp_o[%0d].rvalid", m), DATA_W'(pend[m]),
                   DATA_W'(m_resp[m].rvalid));
         if (pend[m]) check_val($sformatf("m_resp_o[%0d].rdata", m), exp_rd[m], m_resp[m].rdata);
      end
   endtask

   task automatic test_random();
      int                                errs0;
      logic                              granted;
      logic [N_MASTERS_C-1:0]            acc;
      logic [N_MASTERS_C-1:0]            pend;
      logic [N_MASTERS_C-1:0][DATA_W-1:0] exp_rd;
      errs0 = n_errors;
      pend = '0;
      exp_rd = '0;
      for (int w = 0; w < RAND_WORDS; w++) begin
         bus_access(0, ram_addr(w), fill_word(w), '1);
      end
      for (int c = 0; c < RAND_CYC; c++) begin
         @(negedge clk_i);
         check_rd_resp(pend, exp_rd);
         pend = '0;
         acc = '0;
         granted = 1'b0;
         for (int m = N_MASTERS_C - 1; m >= 0; m--) begin  // highest index first
            if (m_req[m].avalid) begin
               acc[m] = !granted;
               granted = 1'b1;
               check_val($sformatf("m_resp_o[%0d].ready", m), DATA_W'(acc[m]),
                         DATA_W'(m_resp[m].ready));
               if (acc[m] && m_req[m].wstrb == '0) begin
                  exp_rd[m] = mdl_read(m_req[m].addr);
                  pend[m] = 1'b1;
               end else if (acc[m]) begin
                  mdl_write(m_req[m].addr, m_req[m].wdata, m_req[m].wstrb);
               end
            end
         end
         @(posedge clk_i);
         for (int m = 0; m < N_MASTERS_C; m++) begin
            if (c == RAND_CYC - 1) m_req[m] <= '0;
            else if (acc[m] || !m_req[m].avalid) m_req[m] <= rand_req();  // else hold
         end
      end
      @(negedge clk_i);
      check_rd_resp(pend, exp_rd);
      test_done("random traffic", errs0);
   endtask

   initial begin
      void'($urandom(32'he66e68ec));
      n_checks = 0;
      n_errors = 0;
      n_tests = 0;
      arst_n_i = 1'b0;
      m_req = '0;
      for (int i = 0; i < 4; i++) reg_mdl[i] = '0;
      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;
      test_ram_rw();
      test_regs();
      test_wr_count();
      test_contention();
      test_random();
      repeat (2) @(posedge clk_i);
      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_T);
      $display("timeout: run did not finish within %0d time units", WATCHDOG_T);
      $display("TB FAILED");
      $finish;
   end

endmodule

/* list.f */
hdl/iob_bus_pkg.sv
hdl/iob_map_pkg.sv
hdl/iob_merge.sv
hdl/iob_split.sv
hdl/iob_ram_slave.sv
hdl/iob_regs_slave.sv
hdl/iob_subsys_top.sv
sim/iob_merge_chk.sv
sim/tb_iob_subsys.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_iob_subsys -f list.f -o tb_iob_subsys \
   || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_iob_subsys)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'TB PASSED' && echo "simulation ok" \
   || { echo "simulation failed"; exit 1; }
